/* common/evt_cfg.svh */
`ifndef EVT_CFG_SVH
`define EVT_CFG_SVH

////////////////////
// Debounce

// Consecutive pressed cycles before a press counts
// Counter width follows from this, keep it a power of two
`define EVT_DEBOUNCE_CYCLES 16

////////////////////
// Event queue

// Event codes held before presses start to drop
`define EVT_FIFO_DEPTH 8

////////////////////
// Bus map

// First register of the event peripheral
// Four-byte window, low two address bits pick the register
`define EVT_BASE_ADDR 8'hD0

`endif

/* common/bus_pkg.sv */
package bus_pkg;

  // Shared 8-bit address and data bus
  typedef logic [7:0] bus_addr_t;
  typedef logic [7:0] bus_data_t;

  // Register index inside a peripheral window
  typedef logic [1:0] reg_off_t;

  ////////////////////
  // Event peripheral registers

  // Read returns head event and pops it
  localparam reg_off_t REG_EVENT = 2'd0;
  // Read returns overflow flag and count
  localparam reg_off_t REG_STATUS = 2'd1;
  // Write with bit 0 set empties the queue
  localparam reg_off_t REG_CLEAR = 2'd2;

endpackage

/* common/evt_pkg.sv */
package evt_pkg;

  // Button index, left 0 and right 1
  typedef logic [1:0] btn_id_t;

  // Sequence number, wraps after 64 presses
  typedef logic [5:0] evt_seq_t;

  // Event code, sequence on top, button below
  typedef logic [7:0] evt_code_t;

  // Queue occupancy, 0 up to depth
  typedef logic [3:0] fifo_cnt_t;

  // Raise/acknowledge interrupt pair
  typedef enum logic {
    IRQ_IDLE,
    IRQ_RAISED
  } irq_state_t;

  ////////////////////
  // Button indices

  localparam btn_id_t BTN_LEFT = 2'd0;
  localparam btn_id_t BTN_RIGHT = 2'd1;

endpackage

/* hw/btn_debounce.sv */
`timescale 1ns/100ps
`include "evt_cfg.svh"

module btn_debounce (
  input  logic                CLK,
  input  logic                rst_n,
  input  logic                btn_l,
  input  logic                btn_r,
  output logic                evt_wr,
  output evt_pkg::evt_code_t  evt_code
);

  import evt_pkg::*;

  localparam int CNT_W = $clog2(`EVT_DEBOUNCE_CYCLES);
  // Counter stops here while the button stays down
  localparam logic [CNT_W-1:0] CNT_SAT = CNT_W'(`EVT_DEBOUNCE_CYCLES - 1);
  // Last step before saturation
  localparam logic [CNT_W-1:0] CNT_QUAL = CNT_W'(`EVT_DEBOUNCE_CYCLES - 2);

  // Index 0 is left, matches BTN_LEFT
  logic [1:0]       btn_in;
  logic [CNT_W-1:0] cnt [2];
  logic [1:0]       qual;
  // Right press waiting behind a left one
  logic             pend_r;
  evt_seq_t         seq;

  assign btn_in = {btn_r, btn_l};

  ////////////////////
  // Saturating counters

  always_ff @(posedge CLK) begin
    for (int i = 0; i < 2; i++) begin
      if (!rst_n || !btn_in[i]) begin
        // Release restarts the count
        cnt[i] <= '0;
      end else if (cnt[i] != CNT_SAT) begin
        cnt[i] <= cnt[i] + 1'b1;
      end
    end
  end

  // Single qualifying cycle per hold
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      qual[i] = btn_in[i] && (cnt[i] == CNT_QUAL);
    end
  end

  ////////////////////
  // Arbitration and pulse

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      evt_wr <= 1'b0;
      pend_r <= 1'b0;
      seq    <= '0;
    end else begin
      evt_wr <= 1'b0;
      if (qual[0]) begin
        // Left wins, right parks in pending bit
        evt_wr <= 1'b1;
        pend_r <= pend_r | qual[1];
        seq    <= seq + 1'b1;
      end else if (pend_r || qual[1]) begin
        evt_wr <= 1'b1;
        pend_r <= 1'b0;
        seq    <= seq + 1'b1;
      end
    end
  end

  // Code payload, same priority as above
  always_ff @(posedge CLK) begin
    if (qual[0]) begin
      evt_code <= {seq, BTN_LEFT};
    end else if (pend_r || qual[1]) begin
      evt_code <= {seq, BTN_RIGHT};
    end
  end

endmodule

/* event_fifo/event_fifo.sv */
`timescale 1ns/100ps
`include "evt_cfg.svh"

module event_fifo #(
  parameter int DEPTH = `EVT_FIFO_DEPTH
) (
  input  logic                CLK,
  input  logic                rst_n,
  input  logic                wr,
  input  evt_pkg::evt_code_t  wr_code,
  input  logic                rd,
  input  logic                clr,
  output evt_pkg::evt_code_t  head,
  output evt_pkg::fifo_cnt_t  count,
  output logic                ovf
);

  import evt_pkg::*;

  // Power-of-two depth, pointers wrap on their own
  localparam int PTR_W = $clog2(DEPTH);
  localparam fifo_cnt_t FULL_CNT = fifo_cnt_t'(DEPTH);

  evt_code_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             full;
  logic             wr_ok;

  assign full = (count == FULL_CNT);
  // A pop in the same cycle frees the slot
  assign wr_ok = wr && (!full || rd);

  // Oldest entry, valid while count is non-zero
  assign head = mem[rd_ptr];

  ////////////////////
  // Pointers and count

  always_ff @(posedge CLK) begin
    if (!rst_n || clr) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      ovf    <= 1'b0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // Pop already gated on non-empty by the bus side
      if (rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Write plus pop leaves count alone
      if (wr_ok && !rd) begin
        count <= count + 1'b1;
      end else if (!wr_ok && rd) begin
        count <= count - 1'b1;
      end
      // Dropped write, sticky until clear
      if (wr && !wr_ok) begin
        ovf <= 1'b1;
      end
    end
  end

  ////////////////////
  // Storage

  always_ff @(posedge CLK) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_code;
    end
  end

endmodule

/* bus_event_io/bus_event_io.sv */
`timescale 1ns/100ps
`include "evt_cfg.svh"

module bus_event_io (
  input  logic                CLK,
  input  logic                rst_n,
  input  bus_pkg::bus_addr_t  bus_addr,
  input  bus_pkg::bus_data_t  bus_wdata,
  input  logic                bus_we,
  input  logic                bus_re,
  output bus_pkg::bus_data_t  bus_rdata,
  output logic                irq_raise,
  input  logic                irq_ack,
  output logic                fifo_rd,
  output logic                fifo_clr,
  input  evt_pkg::evt_code_t  fifo_head,
  input  evt_pkg::fifo_cnt_t  fifo_count,
  input  logic                fifo_ovf
);

  import bus_pkg::*;
  import evt_pkg::*;

  localparam bus_addr_t BASE = `EVT_BASE_ADDR;

  logic       hit;
  reg_off_t   off;
  logic       not_empty;
  bus_data_t  status;
  bus_data_t  rd_mux;
  irq_state_t state;

  ////////////////////
  // Address decode

  // Four-register window above the base
  assign hit = (bus_addr[7:2] == BASE[7:2]);
  assign off = bus_addr[1:0];

  assign not_empty = (fifo_count != '0);

  // Overflow in bit 7, count in the low nibble
  assign status = {fifo_ovf, 3'b000, fifo_count};

  // Pop with the read strobe, never on an empty queue
  assign fifo_rd = bus_re && hit && (off == REG_EVENT) && not_empty;
  // Bit 0 of the written byte requests the clear
  assign fifo_clr = bus_we && hit && (off == REG_CLEAR) && bus_wdata[0];

  ////////////////////
  // Read data

  always_comb begin
    rd_mux = '0;
    if (hit) begin
      case (off)
        REG_EVENT: rd_mux = not_empty ? fifo_head : '0;
        REG_STATUS: rd_mux = status;
        default: rd_mux = '0;
      endcase
    end
  end

  // Loaded on every read strobe, held otherwise
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      bus_rdata <= '0;
    end else if (bus_re) begin
      bus_rdata <= rd_mux;
    end
  end

  ////////////////////
  // Interrupt FSM

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state <= IRQ_IDLE;
    end else begin
      case (state)
        IRQ_IDLE: begin
          // Raise once something is queued
          if (not_empty) begin
            state <= IRQ_RAISED;
          end
        end
        IRQ_RAISED: begin
          // Back to idle for at least a cycle
          if (irq_ack) begin
            state <= IRQ_IDLE;
          end
        end
        default: state <= IRQ_IDLE;
      endcase
    end
  end

  assign irq_raise = (state == IRQ_RAISED);

endmodule

/* hw/event_system.sv */
`timescale 1ns/100ps
`include "evt_cfg.svh"

module event_system (
  input  logic                CLK,
  input  logic                rst_n,
  // Buttons
  input  logic                btn_l,
  input  logic                btn_r,
  // Bus
  input  bus_pkg::bus_addr_t  bus_addr,
  input  bus_pkg::bus_data_t  bus_wdata,
  input  logic                bus_we,
  input  logic                bus_re,
  output bus_pkg::bus_data_t  bus_rdata,
  // Interrupt pair
  output logic                irq_raise,
  input  logic                irq_ack
);

  import evt_pkg::*;

  ////////////////////
  // Internal wires

  // Producer to queue
  logic      evt_wr;
  evt_code_t evt_code;

  // Consumer to queue
  logic      fifo_rd;
  logic      fifo_clr;

  // Queue levels back to consumer
  evt_code_t fifo_head;
  fifo_cnt_t fifo_count;
  logic      fifo_ovf;

  ////////////////////
  // Button events

  btn_debounce debounce_i (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .btn_l    (btn_l),
    .btn_r    (btn_r),
    .evt_wr   (evt_wr),
    .evt_code (evt_code)
  );

  ////////////////////
  // Event queue

  event_fifo #(
    .DEPTH (`EVT_FIFO_DEPTH)
  ) fifo_i (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .wr      (evt_wr),
    .wr_code (evt_code),
    .rd      (fifo_rd),
    .clr     (fifo_clr),
    .head    (fifo_head),
    .count   (fifo_count),
    .ovf     (fifo_ovf)
  );

  ////////////////////
  // Bus peripheral

  bus_event_io bus_io_i (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .bus_addr   (bus_addr),
    .bus_wdata  (bus_wdata),
    .bus_we     (bus_we),
    .bus_re     (bus_re),
    .bus_rdata  (bus_rdata),
    .irq_raise  (irq_raise),
    .irq_ack    (irq_ack),
    .fifo_rd    (fifo_rd),
    .fifo_clr   (fifo_clr),
    .fifo_head  (fifo_head),
    .fifo_count (fifo_count),
    .fifo_ovf   (fifo_ovf)
  );

endmodule

/* tb/event_system_asserts.sv */
`timescale 1ns/100ps
`include "evt_cfg.svh"

module event_system_asserts (
  input logic               CLK,
  input logic               rst_n,
  input bus_pkg::bus_addr_t bus_addr,
  input logic               bus_re,
  input bus_pkg::bus_data_t bus_rdata,
  input logic               irq_raise,
  input logic               irq_ack,
  input logic               evt_wr,
  input logic               fifo_rd,
  input logic               fifo_clr,
  input evt_pkg::fifo_cnt_t fifo_count,
  input logic               fifo_ovf
);

  import bus_pkg::*;
  import evt_pkg::*;

  localparam bus_addr_t ADDR_EVENT = `EVT_BASE_ADDR;
  localparam bus_addr_t ADDR_STATUS = {ADDR_EVENT[7:2], REG_STATUS};
  localparam fifo_cnt_t DEPTH_CNT = fifo_cnt_t'(`EVT_FIFO_DEPTH);

  ////////////////////
  // Reset state

  // First cycle out of reset, all strobes low and queue empty
  reset_quiet: assert property (@(posedge CLK)
    $rose(rst_n) |-> !irq_raise && !evt_wr && !fifo_rd && !fifo_clr
      && bus_rdata == '0 && fifo_count == '0)
    else $error("outputs not idle after reset");

  ////////////////////
  // Queue rules

  count_bound: assert property (@(posedge CLK) disable iff (!rst_n)
    fifo_count <= DEPTH_CNT)
    else $error("queue count above depth");

  // Dropped write on a full queue
  ovf_set: assert property (@(posedge CLK) disable iff (!rst_n)
    evt_wr && fifo_count == DEPTH_CNT && !fifo_rd && !fifo_clr |=> fifo_ovf)
    else $error("overflow flag not set by a dropped write");

  ovf_sticky: assert property (@(posedge CLK) disable iff (!rst_n)
    fifo_ovf && !fifo_clr |=> fifo_ovf)
    else $error("overflow flag dropped without a clear");

  clr_empties: assert property (@(posedge CLK) disable iff (!rst_n)
    fifo_clr |=> fifo_count == '0 && !fifo_ovf)
    else $error("clear left the queue non-empty");

  // Event read on an empty queue leaves it empty
  empty_pop: assert property (@(posedge CLK) disable iff (!rst_n)
    bus_re && bus_addr == ADDR_EVENT && fifo_count == '0 && !evt_wr
      |=> fifo_count == '0)
    else $error("pop on an empty queue changed the count");

  // Pop alone takes one entry
  pop_count: assert property (@(posedge CLK) disable iff (!rst_n)
    fifo_rd && !evt_wr && !fifo_clr |=> fifo_count == $past(fifo_count) - 1'b1)
    else $error("pop did not lower the count by one");

  ////////////////////
  // Interrupt pair

  irq_rise: assert property (@(posedge CLK) disable iff (!rst_n)
    !irq_raise && fifo_count != '0 |=> irq_raise)
    else $error("irq_raise did not rise on a non-empty queue");

  irq_hold: assert property (@(posedge CLK) disable iff (!rst_n)
    irq_raise && !irq_ack |=> irq_raise)
    else $error("irq_raise dropped without an acknowledge");

  irq_drop: assert property (@(posedge CLK) disable iff (!rst_n)
    irq_raise && irq_ack |=> !irq_raise)
    else $error("irq_raise still high after an acknowledge");

  ////////////////////
  // Read data

  rdata_hold: assert property (@(posedge CLK) disable iff (!rst_n)
    !bus_re |=> $stable(bus_rdata))
    else $error("read data changed without a read strobe");

  empty_read: assert property (@(posedge CLK) disable iff (!rst_n)
    bus_re && bus_addr == ADDR_EVENT && fifo_count == '0 |=> bus_rdata == '0)
    else $error("event read on an empty queue not zero");

  status_read: assert property (@(posedge CLK) disable iff (!rst_n)
    bus_re && bus_addr == ADDR_STATUS
      |=> bus_rdata == {$past(fifo_ovf), 3'b000, $past(fifo_count)})
    else $error("status read does not match queue state");

endmodule

bind event_system event_system_asserts asserts_i (
  .CLK        (CLK),
  .rst_n      (rst_n),
  .bus_addr   (bus_addr),
  .bus_re     (bus_re),
  .bus_rdata  (bus_rdata),
  .irq_raise  (irq_raise),
  .irq_ack    (irq_ack),
  .evt_wr     (evt_wr),
  .fifo_rd    (fifo_rd),
  .fifo_clr   (fifo_clr),
  .fifo_count (fifo_count),
  .fifo_ovf   (fifo_ovf)
);

/* tb/tb_event_system.sv */
`timescale 1ns/100ps
`include "evt_cfg.svh"

module tb_event_system;

  import bus_pkg::*;
  import evt_pkg::*;

  localparam int HALF_PERIOD = 20;
  localparam int CLK_PERIOD = 2 * HALF_PERIOD;
  // Held well past the debounce threshold
  localparam int HOLD_CYCLES = `EVT_DEBOUNCE_CYCLES + 4;
  // Longest press that never qualifies
  localparam int GLITCH_MAX = `EVT_DEBOUNCE_CYCLES - 2;
  localparam int GLITCH_COUNT = 6;
  localparam int GAP_MAX = 5;
  localparam int IRQ_WAIT = 8;
  localparam int MAX_OVF_PRESSES = 12;

  localparam bus_addr_t ADDR_EVENT = `EVT_BASE_ADDR;
  localparam bus_addr_t ADDR_STATUS = {ADDR_EVENT[7:2], REG_STATUS};
  localparam bus_addr_t ADDR_CLEAR = {ADDR_EVENT[7:2], REG_CLEAR};

  ////////////////////
  // Run time budget

  // Cycle estimates per test, bus accesses about 3 cycles each
  localparam int T_RESET = 10;
  localparam int T_GLITCH = GLITCH_COUNT * (GLITCH_MAX + GAP_MAX + 1) + 20;
  localparam int T_SINGLE = HOLD_CYCLES + IRQ_WAIT + 30;
  localparam int T_BOTH = HOLD_CYCLES + IRQ_WAIT + 40;
  localparam int T_OVF = MAX_OVF_PRESSES * (HOLD_CYCLES + GAP_MAX + 1)
    + 3 * `EVT_FIFO_DEPTH + 40;
  localparam int WATCHDOG_NS =
    2 * (T_RESET + T_GLITCH + T_SINGLE + T_BOTH + T_OVF) * CLK_PERIOD;

  logic      CLK;
  logic      rst_n;
  logic      btn_l;
  logic      btn_r;
  bus_addr_t bus_addr;
  bus_data_t bus_wdata;
  logic      bus_we;
  logic      bus_re;
  bus_data_t bus_rdata;
  logic      irq_raise;
  logic      irq_ack;

  integer    seed;
  int        test_errs;
  int        total_errs;
  int        tests_run;
  int        tests_failed;
  // Model of the queue contents and the next sequence number
  evt_code_t exp_q[$];
  evt_seq_t  next_seq;

  event_system dut_i (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .btn_l     (btn_l),
    .btn_r     (btn_r),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_we    (bus_we),
    .bus_re    (bus_re),
    .bus_rdata (bus_rdata),
    .irq_raise (irq_raise),
    .irq_ack   (irq_ack)
  );

  always #(HALF_PERIOD) CLK = ~CLK;

  ////////////////////
  // Reference model

  // Sequence on top, button index below
  function automatic evt_code_t make_code(evt_seq_t s, btn_id_t b);
    return {s, b};
  endfunction

  // Overflow in bit 7, modeled count in the low nibble
  function automatic bus_data_t status_of(logic ovf);
    return {ovf, 3'b000, 4'(exp_q.size())};
  endfunction

  function automatic int rand_range(int lo, int hi);
    int r;
    r = $unsigned($random(seed)) % (hi - lo + 1);
    return lo + r;
  endfunction

  // Every accepted press steps the sequence, dropped ones too
  task automatic expect_code(btn_id_t b);
    if (exp_q.size() < `EVT_FIFO_DEPTH) begin
      exp_q.push_back(make_code(next_seq, b));
    end
    next_seq++;
  endtask

  ////////////////////
  // Bus and button drivers

  task automatic idle_cycles(int n);
    repeat (n) @(posedge CLK);
  endtask

  // Buttons sampled down on n edges, then released
  task automatic hold_buttons(logic l, logic r, int n);
    @(posedge CLK);
    btn_l <= l;
    btn_r <= r;
    repeat (n) @(posedge CLK);
    btn_l <= 1'b0;
    btn_r <= 1'b0;
  endtask

  // Full press, left code ahead of right
  task automatic press(logic l, logic r, int gap);
    hold_buttons(l, r, HOLD_CYCLES);
    if (l) begin
      expect_code(BTN_LEFT);
    end
    if (r) begin
      expect_code(BTN_RIGHT);
    end
    idle_cycles(gap);
  endtask

  task automatic read_reg(bus_addr_t addr, output bus_data_t data);
    @(posedge CLK);
    bus_addr <= addr;
    bus_re   <= 1'b1;
    @(posedge CLK);
    bus_re   <= 1'b0;
    // Registered data, settled by the falling edge
    @(negedge CLK);
    data = bus_rdata;
  endtask

  task automatic write_reg(bus_addr_t addr, bus_data_t data);
    @(posedge CLK);
    bus_addr  <= addr;
    bus_wdata <= data;
    bus_we    <= 1'b1;
    @(posedge CLK);
    bus_we    <= 1'b0;
  endtask

  task automatic ack_irq();
    @(posedge CLK);
    irq_ack <= 1'b1;
    @(posedge CLK);
    irq_ack <= 1'b0;
  endtask

  ////////////////////
  // Checks

  task automatic check_byte(string what, bus_data_t got, bus_data_t exp);
    assert (got == exp) else begin
      $display("[ERROR] %0t ns: %s expected 8'h%02h, got 8'h%02h", $time, what, exp, got);
      test_errs++;
    end
  endtask

  task automatic check_irq_low(string when);
    @(negedge CLK);
    assert (!irq_raise) else begin
      $display("[ERROR] %0t ns: irq_raise is high %s", $time, when);
      test_errs++;
    end
  endtask

  task automatic wait_for_irq(int limit);
    int n;
    n = 0;
    @(negedge CLK);
    while (!irq_raise && n < limit) begin
      @(negedge CLK);
      n++;
    end
    assert (irq_raise) else begin
      $display("irq_raise did not rise within %0d cycles at %0t ns", limit, $time);
      test_errs++;
    end
  endtask

  // Pops n codes and compares them in queue order
  task automatic read_expected(int n);
    bus_data_t got;
    evt_code_t exp;
    for (int i = 0; i < n; i++) begin
      exp = exp_q.pop_front();
      read_reg(ADDR_EVENT, got);
      check_byte("event read", got, exp);
    end
  endtask

  task automatic finish_test(string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("%0t ns: test %s done, no errors", $time, name);
    end else begin
      $display("%0t ns: test %s done, %0d errors", $time, name, test_errs);
      tests_failed++;
    end
    total_errs += test_errs;
    test_errs = 0;
  endtask

  ////////////////////
  // Tests

  task automatic test_reset();
    bus_data_t got;
    check_irq_low("after reset");
    read_reg(ADDR_STATUS, got);
    check_byte("status after reset", got, 8'h00);
    finish_test("reset");
  endtask

  // Left, right and both in turn, all too short
  task automatic test_glitch();
    bus_data_t got;
    for (int i = 0; i < GLITCH_COUNT; i++) begin
      hold_buttons((i % 3) != 1, (i % 3) != 0, rand_range(1, GLITCH_MAX));
      idle_cycles(rand_range(1, GAP_MAX));
    end
    idle_cycles(4);
    check_irq_low("after short presses");
    read_reg(ADDR_STATUS, got);
    check_byte("status after short presses", got, status_of(1'b0));
    finish_test("glitch");
  endtask

  task automatic test_single();
    bus_data_t got;
    press(1'b1, 1'b0, 2);
    wait_for_irq(IRQ_WAIT);
    read_reg(ADDR_STATUS, got);
    check_byte("status after one press", got, status_of(1'b0));
    read_expected(1);
    // Queue now empty, event register reads zero
    read_reg(ADDR_EVENT, got);
    check_byte("event read on an empty queue", got, 8'h00);
    ack_irq();
    idle_cycles(3);
    check_irq_low("with the queue empty");
    finish_test("single press");
  endtask

  task automatic test_both();
    bus_data_t got;
    press(1'b1, 1'b1, 2);
    wait_for_irq(IRQ_WAIT);
    read_reg(ADDR_STATUS, got);
    check_byte("status after both pressed", got, status_of(1'b0));
    read_expected(2);
    ack_irq();
    idle_cycles(3);
    check_irq_low("with the queue empty");
    finish_test("simultaneous press");
  endtask

  task automatic test_overflow();
    bus_data_t got;
    int        n;
    n = rand_range(9, MAX_OVF_PRESSES);
    for (int i = 0; i < n; i++) begin
      press((i % 2) == 0, (i % 2) == 1, rand_range(1, GAP_MAX));
    end
    wait_for_irq(IRQ_WAIT);
    read_reg(ADDR_STATUS, got);
    check_byte("status on a full queue", got, status_of(1'b1));
    read_expected(`EVT_FIFO_DEPTH);
    read_reg(ADDR_STATUS, got);
    check_byte("status after draining", got, status_of(1'b1));
    write_reg(ADDR_CLEAR, 8'h01);
    exp_q.delete();
    read_reg(ADDR_STATUS, got);
    check_byte("status after clear", got, status_of(1'b0));
    ack_irq();
    idle_cycles(3);
    check_irq_low("after clear and acknowledge");
    finish_test($sformatf("overflow with %0d presses", n));
  endtask

  ////////////////////
  // Main sequence

  initial begin
    seed = 32'h7752_31df;
    CLK = 1'b0;
    rst_n = 1'b0;
    btn_l = 1'b0;
    btn_r = 1'b0;
    bus_addr = '0;
    bus_wdata = '0;
    bus_we = 1'b0;
    bus_re = 1'b0;
    irq_ack = 1'b0;
    test_errs = 0;
    total_errs = 0;
    tests_run = 0;
    tests_failed = 0;
    next_seq = '0;
    repeat (2) @(posedge CLK);
    rst_n <= 1'b1;
    test_reset();
    test_glitch();
    test_single();
    test_both();
    test_overflow();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
    if (total_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Hung handshake or stuck wait ends here
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* all.f */
+incdir+common
common/bus_pkg.sv
common/evt_pkg.sv
hw/btn_debounce.sv
event_fifo/event_fifo.sv
bus_event_io/bus_event_io.sv
hw/event_system.sv
tb/event_system_asserts.sv
tb/tb_event_system.sv

/* Makefile */
SIM := obj_dir/Vtb_event_system
SRC := $(wildcard common/*.sv common/*.svh hw/*.sv event_fifo/*.sv bus_event_io/*.sv tb/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): all.f $(SRC)
	verilator --binary --timing --assert --top-module tb_event_system -Mdir obj_dir -f all.f

# Pass only when the log holds the pass line
run: $(SIM)
	$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
